//--- mmu_top.f
hw/mmu_pkg.sv
hw/mmu_inst.sv
hw/mmu_data.sv
hw/mmu_read_arbiter.sv
hw/mmu_top.sv
sim/axi_mem_model.sv
sim/mmu_top_props.sv
sim/tb_mmu_top.sv

//--- sim/tb_mmu_top.sv
`timescale 1ns/1ps

module tb_mmu_top
    import mmu_pkg::*;
();

    localparam int NUM_TESTS = 7;
    localparam int SEED      = 88805;

    logic       clk;
    logic       rst_n;
    logic       inst_en;
    addr_t      inst_addr;
    logic       inst_uncached;
    logic       inst_ok;
    logic       inst_ok_1;
    logic       inst_ok_2;
    word_t      inst_data_1;
    word_t      inst_data_2;
    logic       data_en;
    strb_t      data_wen;
    addr_t      data_addr;
    word_t      data_wdata;
    logic       data_ok;
    word_t      data_data;
    addr_t      araddr;
    blen_t      arlen;
    logic [1:0] arburst;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic       rlast;
    logic       rvalid;
    addr_t      awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       wvalid;
    logic       wready;
    logic       bvalid;

    integer seed = SEED;
    int     errors = 0;
    int     checks = 0;
    int     tests_done = 0;
    int     cycles = 0;
    int     limit;
    // Expected contents of the data region from 0x1000
    word_t  shadow [1024];

    mmu_top i_mmu_top (.*);

    axi_mem_model #(
        .SEED (SEED)
    ) u_mem (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic word_t mem_rule(input addr_t a);
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t strb);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                r[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return r;
    endfunction

    function automatic int total_errors();
        return errors + i_mmu_top.u_props.fail_count;
    endfunction

    task automatic report_value(input string name, input word_t got, input word_t exp);
        errors++;
        $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("At %0t ns: %s", $time, what);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_done++;
        $display("test %0d %-20s %s", tests_done, name,
                 (total_errors() == errs_before) ? "ok" : "errors");
    endtask

    task automatic fetch(input addr_t addr, input logic unc);
        logic last_word;
        last_word = ((addr >> 2) % i_mmu_top.LINE_WORDS) == i_mmu_top.LINE_WORDS - 1;
        @(posedge clk);
        inst_en       <= 1'b1;
        inst_addr     <= addr;
        inst_uncached <= unc;
        do begin
            @(posedge clk);
        end while (!inst_ok);
        inst_en <= 1'b0;
        checks++;
        assert (inst_ok_1)
            else report_fault("inst_ok_1 stayed low while inst_ok was high");
        assert (inst_data_1 == mem_rule(addr))
            else report_value("inst_data_1", inst_data_1, mem_rule(addr));
        if (unc || last_word) begin
            assert (!inst_ok_2)
                else report_fault("inst_ok_2 high on an uncached fetch or at the line end");
        end else begin
            assert (inst_ok_2)
                else report_fault("inst_ok_2 low although the next word is in the line");
            assert (inst_data_2 == mem_rule(addr + 32'd4))
                else report_value("inst_data_2", inst_data_2, mem_rule(addr + 32'd4));
        end
    endtask

    task automatic access(input addr_t addr, input strb_t wen, input word_t wd);
        int idx;
        idx = (addr - 32'h1000) >> 2;
        @(posedge clk);
        data_en    <= 1'b1;
        data_wen   <= wen;
        data_addr  <= addr;
        data_wdata <= wd;
        do begin
            @(posedge clk);
        end while (!data_ok);
        data_en  <= 1'b0;
        data_wen <= '0;
        checks++;
        if (wen != '0) begin
            shadow[idx] = merge_bytes(shadow[idx], wd, wen);
        end else begin
            assert (data_data == shadow[idx])
                else report_value("data_data", data_data, shadow[idx]);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, a request never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        int    errs;
        int    lbytes;
        addr_t line_a;
        addr_t da;
        strb_t wen;
        limit         = NUM_TESTS * 64 * i_mmu_top.LINE_WORDS;
        lbytes        = i_mmu_top.LINE_WORDS * 4;
        rst_n         = 1'b0;
        inst_en       = 1'b0;
        inst_addr     = '0;
        inst_uncached = 1'b0;
        data_en       = 1'b0;
        data_wen      = '0;
        data_addr     = '0;
        data_wdata    = '0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = mem_rule(32'h1000 + i * 4);
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;

        errs = total_errors();
        repeat (20) @(posedge clk);
        end_test("reset_quiet", errs);

        // Instruction lines stay below 0x800 so xor with 0x400 or 0x800 picks other lines
        errs   = total_errors();
        line_a = ($random(seed) & 32'h7FF) & ~(lbytes - 1);
        fetch(line_a + (($random(seed) & (i_mmu_top.LINE_WORDS - 1)) << 2), 1'b0);
        end_test("inst_miss", errs);

        errs = total_errors();
        repeat (4) begin
            fetch(line_a + (($random(seed) & (i_mmu_top.LINE_WORDS - 1)) << 2), 1'b0);
        end
        fetch(line_a + lbytes - 4, 1'b0);
        fetch(line_a + lbytes - 4, 1'b0);
        fetch(line_a, 1'b0);
        end_test("inst_hits", errs);

        errs = total_errors();
        fetch((line_a ^ 32'h800) + 32'd8, 1'b1);
        fetch(line_a + 32'd4, 1'b0);
        end_test("inst_uncached", errs);

        errs = total_errors();
        repeat (8) begin
            da  = 32'h1000 + ($random(seed) & 32'hFFC);
            wen = strb_t'($random(seed));
            if (wen == '0) begin
                wen = 4'hF;
            end
            access(da, wen, $random(seed));
            access(da, '0, '0);
        end
        end_test("data_write_read", errs);

        errs = total_errors();
        da   = 32'h1000 + ($random(seed) & 32'hFFC);
        fork
            fetch((line_a ^ 32'h400) + 32'd12, 1'b0);
            access(da, '0, '0);
        join
        end_test("read_contention", errs);

        errs = total_errors();
        da   = 32'h1000 + ($random(seed) & 32'hFFC);
        fork
            fetch((line_a ^ 32'hC00) + 32'd4, 1'b0);
            begin
                repeat (2) @(posedge clk);
                access(da, 4'b0101, $random(seed));
            end
        join
        access(da, '0, '0);
        end_test("write_during_refill", errs);

        $display("tests %0d, checks %0d, check errors %0d, assertion failures %0d",
                 tests_done, checks, errors, i_mmu_top.u_props.fail_count);
        if (total_errors() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- sim/mmu_top_props.sv
`timescale 1ns/1ps

module mmu_top_props
    import mmu_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input logic       clk,
    input logic       rst_n,
    input logic       inst_en,
    input addr_t      inst_addr,
    input logic       inst_uncached,
    input logic       inst_ok,
    input logic       inst_ok_1,
    input logic       data_en,
    input logic       data_ok,
    input addr_t      araddr,
    input blen_t      arlen,
    input logic [1:0] arburst,
    input logic       arvalid,
    input logic       arready,
    input logic       rvalid,
    input logic       rlast,
    input addr_t      awaddr,
    input logic       awvalid,
    input logic       awready,
    input word_t      wdata,
    input strb_t      wstrb,
    input logic       wlast,
    input logic       wvalid,
    input logic       wready,
    input logic       i_ar_valid,
    input logic       i_ar_ready,
    input logic       d_ar_valid,
    input logic       d_ar_ready
);

    localparam int OFF_W = $clog2(LINE_WORDS);

    int unsigned fail_count = 0;
    logic        seen_req;
    logic        rd_open;
    logic        d_first;
    logic        i_ar_q;
    logic        d_ar_q;
    logic        new_pair;
    logic        inst_en_q;
    logic        fill_open;
    logic        line_ok;
    addr_t       line_addr;
    logic        same_line;
    logic        expect_hit;

    // Both units raise a fresh read request in the same cycle
    assign new_pair = i_ar_valid && !i_ar_q && d_ar_valid && !d_ar_q;

    // Line held by the fetch unit, as seen from its last completed refill
    assign same_line  = (inst_addr >> (OFF_W + 2)) == (line_addr >> (OFF_W + 2));
    assign expect_hit = inst_en && !inst_en_q && !inst_uncached && line_ok && same_line;

    always @(posedge clk) begin
        if (!rst_n) begin
            seen_req  <= 1'b0;
            rd_open   <= 1'b0;
            d_first   <= 1'b0;
            i_ar_q    <= 1'b0;
            d_ar_q    <= 1'b0;
            inst_en_q <= 1'b0;
            fill_open <= 1'b0;
            line_ok   <= 1'b0;
        end else begin
            i_ar_q    <= i_ar_valid;
            d_ar_q    <= d_ar_valid;
            inst_en_q <= inst_en;
            if (inst_en || data_en) begin
                seen_req <= 1'b1;
            end
            if (arvalid && arready) begin
                rd_open <= 1'b1;
            end else if (rvalid && rlast) begin
                rd_open <= 1'b0;
            end
            if (d_ar_ready) begin
                d_first <= 1'b0;
            end else if (new_pair) begin
                d_first <= 1'b1;
            end
            if (arvalid && arready && i_ar_ready && arburst == BURST_INCR) begin
                line_ok   <= 1'b0;
                fill_open <= 1'b1;
                line_addr <= araddr;
            end else if (fill_open && rvalid && rlast) begin
                line_ok   <= 1'b1;
                fill_open <= 1'b0;
            end
        end
    end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req |-> !(inst_ok || data_ok || arvalid || awvalid || wvalid))
        else begin
            fail_count++;
            $error("control output active before any request");
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        expect_hit |=> inst_ok && inst_ok_1)
        else begin
            fail_count++;
            $error("instruction hit not answered in the next cycle");
        end

    a_refill_len: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready && i_ar_ready && !inst_uncached
        |-> arlen == blen_t'(LINE_WORDS - 1) && arburst == BURST_INCR)
        else begin
            fail_count++;
            $error("line refill with wrong arlen or arburst");
        end

    a_single_len: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && arready && (d_ar_ready || (i_ar_ready && inst_uncached)) |-> arlen == '0)
        else begin
            fail_count++;
            $error("single read with nonzero arlen");
        end

    a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready
        |=> arvalid && $stable(araddr) && $stable(arlen) && $stable(arburst))
        else begin
            fail_count++;
            $error("read address dropped or changed while stalled");
        end

    a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            fail_count++;
            $error("write address dropped or changed while stalled");
        end

    a_w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else begin
            fail_count++;
            $error("write data dropped or changed while stalled");
        end

    a_wlast: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> wlast)
        else begin
            fail_count++;
            $error("write beat without wlast");
        end

    a_one_burst: assert property (@(posedge clk) disable iff (!rst_n)
        rd_open |-> !(arvalid && arready))
        else begin
            fail_count++;
            $error("second read address accepted inside a burst");
        end

    a_data_first: assert property (@(posedge clk) disable iff (!rst_n)
        (d_first || new_pair) |-> !i_ar_ready)
        else begin
            fail_count++;
            $error("instruction read granted ahead of a data read");
        end

endmodule

bind mmu_top mmu_top_props #(
    .LINE_WORDS (LINE_WORDS)
) u_props (
    .*
);

//--- sim/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model
    import mmu_pkg::*;
#(
    parameter int SEED = 1
) (
    input  logic       clk,
    input  logic       rst_n,
    input  addr_t      araddr,
    input  blen_t      arlen,
    input  logic [1:0] arburst,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata,
    output logic       rlast,
    output logic       rvalid,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      wdata,
    input  strb_t      wstrb,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid
);

    // 8 KB covers both the instruction and the data region
    word_t  mem [2048];
    integer seed;
    logic   rd_busy;
    addr_t  rd_addr;
    blen_t  rd_len;
    blen_t  rd_cnt;
    logic   rd_incr;
    logic   aw_got;
    logic   w_got;
    addr_t  wr_addr;
    word_t  wr_data;
    strb_t  wr_strb;

    initial begin
        seed = SEED;
        for (int i = 0; i < 2048; i++) begin
            mem[i] = (i << 2) ^ 32'hA5A5_0000;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_busy <= 1'b0;
        end else if (rd_busy) begin
            // One beat per cycle since rready is tied high
            rvalid  <= 1'b1;
            rdata   <= mem[rd_addr[12:2]];
            rlast   <= (rd_cnt == rd_len);
            rd_busy <= (rd_cnt != rd_len);
            rd_cnt  <= rd_cnt + 1'b1;
            if (rd_incr) begin
                rd_addr <= rd_addr + 32'd4;
            end
        end else begin
            rvalid <= 1'b0;
            rlast  <= 1'b0;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_len  <= arlen;
                rd_cnt  <= '0;
                rd_incr <= (arburst == BURST_INCR);
                arready <= 1'b0;
            end else begin
                arready <= ($random(seed) & 3) != 0;
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
        end else begin
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 1) != 0;
            bvalid  <= 1'b0;
            if (awvalid && awready) begin
                aw_got  <= 1'b1;
                wr_addr <= awaddr;
            end
            if (wvalid && wready) begin
                w_got   <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            // Commit one cycle after both halves are in
            if (aw_got && w_got) begin
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        mem[wr_addr[12:2]][8*b +: 8] <= wr_data[8*b +: 8];
                    end
                end
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                bvalid <= 1'b1;
            end
        end
    end

endmodule

//--- hw/mmu_top.sv
`timescale 1ns/1ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    // Instruction side
    input  logic       inst_en,
    input  addr_t      inst_addr,
    input  logic       inst_uncached,
    output logic       inst_ok,
    output logic       inst_ok_1,
    output logic       inst_ok_2,
    output word_t      inst_data_1,
    output word_t      inst_data_2,
    // Data side
    input  logic       data_en,
    input  strb_t      data_wen,
    input  addr_t      data_addr,
    input  word_t      data_wdata,
    output logic       data_ok,
    output word_t      data_data,
    // Read channels
    output addr_t      araddr,
    output blen_t      arlen,
    output logic [1:0] arburst,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata,
    input  logic       rlast,
    input  logic       rvalid,
    // Write channels
    output addr_t      awaddr,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid
);

    logic    i_ar_valid;
    logic    i_ar_ready;
    logic    i_r_valid;
    ar_req_t i_ar_req;
    logic    d_ar_valid;
    logic    d_ar_ready;
    logic    d_r_valid;
    ar_req_t d_ar_req;
    ar_req_t ar_out;
    r_beat_t r_beat;
    w_req_t  w_req;

    assign r_beat = '{data: rdata, last: rlast};

    mmu_inst #(
        .LINE_WORDS (LINE_WORDS)
    ) u_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_en       (inst_en),
        .inst_addr     (inst_addr),
        .inst_uncached (inst_uncached),
        .inst_ok       (inst_ok),
        .inst_ok_1     (inst_ok_1),
        .inst_ok_2     (inst_ok_2),
        .inst_data_1   (inst_data_1),
        .inst_data_2   (inst_data_2),
        .ar_valid      (i_ar_valid),
        .ar_req        (i_ar_req),
        .ar_ready      (i_ar_ready),
        .r_valid       (i_r_valid),
        .r_beat        (r_beat)
    );

    mmu_data u_data (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_en    (data_en),
        .data_wen   (data_wen),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ok    (data_ok),
        .data_data  (data_data),
        .ar_valid   (d_ar_valid),
        .ar_req     (d_ar_req),
        .ar_ready   (d_ar_ready),
        .r_valid    (d_r_valid),
        .r_beat     (r_beat),
        .awvalid    (awvalid),
        .wvalid     (wvalid),
        .w_req      (w_req),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid)
    );

    mmu_read_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (i_ar_valid),
        .i_req    (i_ar_req),
        .i_ready  (i_ar_ready),
        .d_valid  (d_ar_valid),
        .d_req    (d_ar_req),
        .d_ready  (d_ar_ready),
        .arvalid  (arvalid),
        .ar_out   (ar_out),
        .arready  (arready),
        .rvalid   (rvalid),
        .r_beat   (r_beat),
        .i_rvalid (i_r_valid),
        .d_rvalid (d_r_valid)
    );

    assign araddr  = ar_out.addr;
    assign arlen   = ar_out.len;
    assign arburst = ar_out.incr ? BURST_INCR : BURST_FIXED;

    // Single beat writes only
    assign awaddr = w_req.addr;
    assign wdata  = w_req.data;
    assign wstrb  = w_req.strb;
    assign wlast  = 1'b1;

endmodule

//--- hw/mmu_read_arbiter.sv
`timescale 1ns/1ps

module mmu_read_arbiter
    import mmu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    i_valid,
    input  ar_req_t i_req,
    output logic    i_ready,
    input  logic    d_valid,
    input  ar_req_t d_req,
    output logic    d_ready,
    output logic    arvalid,
    output ar_req_t ar_out,
    input  logic    arready,
    input  logic    rvalid,
    input  r_beat_t r_beat,
    output logic    i_rvalid,
    output logic    d_rvalid
);

    logic own_d;
    logic hold_r;
    logic busy_r;
    logic held;
    logic sel_d;

    // Keep the choice while an address waits and until the burst ends
    assign held  = hold_r || busy_r;
    assign sel_d = held ? own_d : d_valid;

    assign arvalid = !busy_r && (sel_d ? d_valid : i_valid);
    assign ar_out  = sel_d ? d_req : i_req;
    assign d_ready = !busy_r && sel_d && arready;
    assign i_ready = !busy_r && !sel_d && arready;

    // Beats only go to the unit that owns the burst
    assign d_rvalid = rvalid && busy_r && own_d;
    assign i_rvalid = rvalid && busy_r && !own_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            own_d  <= 1'b0;
            hold_r <= 1'b0;
            busy_r <= 1'b0;
        end else begin
            if (!held) begin
                own_d <= d_valid;
            end
            if (arvalid) begin
                hold_r <= !arready;
            end
            if (arvalid && arready) begin
                busy_r <= 1'b1;
            end else if (busy_r && rvalid && r_beat.last) begin
                busy_r <= 1'b0;
            end
        end
    end

endmodule

//--- hw/mmu_data.sv
`timescale 1ns/1ps

module mmu_data
    import mmu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    data_en,
    input  strb_t   data_wen,
    input  addr_t   data_addr,
    input  word_t   data_wdata,
    output logic    data_ok,
    output word_t   data_data,
    output logic    ar_valid,
    output ar_req_t ar_req,
    input  logic    ar_ready,
    input  logic    r_valid,
    input  r_beat_t r_beat,
    output logic    awvalid,
    output logic    wvalid,
    output w_req_t  w_req,
    input  logic    awready,
    input  logic    wready,
    input  logic    bvalid
);

    data_state_t state;
    logic        ok_r;
    logic        aw_pend;
    logic        w_pend;
    logic        aw_done;
    logic        w_done;
    word_t       rdata_r;

    // Core holds the request fields until data_ok
    assign ar_req = '{addr: data_addr, len: '0, incr: 1'b0};
    assign w_req  = '{addr: data_addr, data: data_wdata, strb: data_wen};

    assign aw_done = !aw_pend || awready;
    assign w_done  = !w_pend || wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= DATA_IDLE;
            ok_r    <= 1'b0;
            aw_pend <= 1'b0;
            w_pend  <= 1'b0;
        end else begin
            ok_r <= 1'b0;
            case (state)
                DATA_IDLE: begin
                    // Skip the ok cycle while the request is still up
                    if (data_en && !ok_r) begin
                        if (|data_wen) begin
                            aw_pend <= 1'b1;
                            w_pend  <= 1'b1;
                            state   <= DATA_AW_W;
                        end else begin
                            state <= DATA_AR_WAIT;
                        end
                    end
                end
                DATA_AR_WAIT: begin
                    if (ar_ready) begin
                        state <= DATA_R_WAIT;
                    end
                end
                DATA_R_WAIT: begin
                    if (r_valid && r_beat.last) begin
                        ok_r  <= 1'b1;
                        state <= DATA_IDLE;
                    end
                end
                DATA_AW_W: begin
                    if (awready) begin
                        aw_pend <= 1'b0;
                    end
                    if (wready) begin
                        w_pend <= 1'b0;
                    end
                    if (aw_done && w_done) begin
                        state <= DATA_B_WAIT;
                    end
                end
                DATA_B_WAIT: begin
                    if (bvalid) begin
                        ok_r  <= 1'b1;
                        state <= DATA_IDLE;
                    end
                end
                default: begin
                    state <= DATA_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DATA_R_WAIT && r_valid) begin
            rdata_r <= r_beat.data;
        end
    end

    assign data_ok   = ok_r;
    assign data_data = rdata_r;
    assign ar_valid  = (state == DATA_AR_WAIT);
    assign awvalid   = (state == DATA_AW_W) && aw_pend;
    assign wvalid    = (state == DATA_AW_W) && w_pend;

endmodule

//--- hw/mmu_inst.sv
`timescale 1ns/1ps

module mmu_inst
    import mmu_pkg::*;
#(
    parameter int LINE_WORDS = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    inst_en,
    input  addr_t   inst_addr,
    input  logic    inst_uncached,
    output logic    inst_ok,
    output logic    inst_ok_1,
    output logic    inst_ok_2,
    output word_t   inst_data_1,
    output word_t   inst_data_2,
    output logic    ar_valid,
    output ar_req_t ar_req,
    input  logic    ar_ready,
    input  logic    r_valid,
    input  r_beat_t r_beat
);

    localparam int OFF_W = $clog2(LINE_WORDS);
    localparam int TAG_W = 30 - OFF_W;

    inst_state_t      state;
    logic             line_valid;
    logic [TAG_W-1:0] line_tag;
    word_t            line_mem [LINE_WORDS];
    logic [OFF_W-1:0] beat_cnt;
    logic             unc_r;
    logic             ok2_r;
    word_t            data1_r;
    word_t            data2_r;

    logic [TAG_W-1:0] req_tag;
    logic [OFF_W-1:0] req_idx;
    logic [OFF_W-1:0] nxt_idx;
    logic             hit;

    assign req_tag = inst_addr[31:OFF_W+2];
    assign req_idx = inst_addr[OFF_W+1:2];
    assign nxt_idx = req_idx + 1'b1;
    assign hit     = line_valid && (line_tag == req_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= INST_IDLE;
            line_valid <= 1'b0;
            unc_r      <= 1'b0;
            ok2_r      <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            case (state)
                INST_IDLE: begin
                    if (inst_en) begin
                        if (inst_uncached) begin
                            unc_r <= 1'b1;
                            state <= INST_AR_WAIT;
                        end else if (hit) begin
                            // Second word only if it stays in this line
                            ok2_r <= (req_idx != OFF_W'(LINE_WORDS - 1));
                            state <= INST_HIT_OUT;
                        end else begin
                            unc_r      <= 1'b0;
                            line_valid <= 1'b0;
                            state      <= INST_AR_WAIT;
                        end
                    end
                end
                INST_HIT_OUT: begin
                    state <= INST_IDLE;
                end
                INST_AR_WAIT: begin
                    if (ar_ready) begin
                        beat_cnt <= '0;
                        state    <= unc_r ? INST_UNC_WAIT : INST_REFILL;
                    end
                end
                INST_REFILL: begin
                    if (r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        // Replay as a hit once the line is complete
                        if (r_beat.last) begin
                            line_valid <= 1'b1;
                            state      <= INST_IDLE;
                        end
                    end
                end
                INST_UNC_WAIT: begin
                    if (r_valid) begin
                        ok2_r <= 1'b0;
                        state <= INST_HIT_OUT;
                    end
                end
                default: begin
                    state <= INST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == INST_IDLE && inst_en) begin
            data1_r <= line_mem[req_idx];
            data2_r <= line_mem[nxt_idx];
            if (inst_uncached) begin
                ar_req <= '{addr: inst_addr, len: '0, incr: 1'b0};
            end else begin
                // Line aligned refill
                ar_req <= '{addr: {req_tag, {(OFF_W + 2){1'b0}}},
                            len:  blen_t'(LINE_WORDS - 1),
                            incr: 1'b1};
            end
            if (!inst_uncached && !hit) begin
                line_tag <= req_tag;
            end
        end
        if (state == INST_REFILL && r_valid) begin
            line_mem[beat_cnt] <= r_beat.data;
        end
        if (state == INST_UNC_WAIT && r_valid) begin
            data1_r <= r_beat.data;
        end
    end

    assign inst_ok     = (state == INST_HIT_OUT);
    assign inst_ok_1   = (state == INST_HIT_OUT);
    assign inst_ok_2   = (state == INST_HIT_OUT) && ok2_r;
    assign inst_data_1 = data1_r;
    assign inst_data_2 = data2_r;
    assign ar_valid    = (state == INST_AR_WAIT);

endmodule

//--- hw/mmu_pkg.sv
package mmu_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    // Beats minus one
    typedef logic [7:0]  blen_t;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;

    typedef struct packed {
        addr_t addr;
        blen_t len;
        logic  incr;
    } ar_req_t;

    typedef struct packed {
        word_t data;
        logic  last;
    } r_beat_t;

    typedef struct packed {
        addr_t addr;
        word_t data;
        strb_t strb;
    } w_req_t;

    typedef enum logic [2:0] {
        INST_IDLE,
        INST_HIT_OUT,
        INST_AR_WAIT,
        INST_REFILL,
        INST_UNC_WAIT
    } inst_state_t;

    typedef enum logic [2:0] {
        DATA_IDLE,
        DATA_AR_WAIT,
        DATA_R_WAIT,
        DATA_AW_W,
        DATA_B_WAIT
    } data_state_t;

endpackage
